/* mesh_settings.svh */
`ifndef MESH_SETTINGS_SVH
`define MESH_SETTINGS_SVH

// mesh size, columns then rows
`define NX 4
`define NY 4

// body flit payload, also the full flit word
`define PAYLOAD_W 16

// entries in the route queue
`define FIFO_DEPTH 4

`endif

/* mesh_flit_pkg.sv */
`default_nettype none

`include "mesh_settings.svh"

package mesh_flit_pkg;

    localparam int X_W   = $clog2(`NX);            // column address bits
    localparam int Y_W   = $clog2(`NY);            // row address bits
    localparam int TAG_W = `PAYLOAD_W - X_W - Y_W; // rest of the head word

    typedef logic [X_W-1:0] x_coord_t;
    typedef logic [Y_W-1:0] y_coord_t;

    // one flit word, read as a head or as a body
    typedef union packed {
        struct packed {
            x_coord_t         dest_x;
            y_coord_t         dest_y;
            logic [TAG_W-1:0] tag;
        } head;
        logic [`PAYLOAD_W-1:0] payload; // body view, whole word
    } flit_t;

endpackage

`default_nettype wire

/* mesh_port_pkg.sv */
`default_nettype none

package mesh_port_pkg;

    localparam int PORT_CNT = 5; // always five ports in a 2D mesh

    // index into a port set
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_idx_t;

    typedef logic [PORT_CNT-1:0] port_set_t;

    localparam port_set_t LOCAL_PORT = 5'b00001;
    localparam port_set_t X_PORTS    = 5'b01010; // east, west
    localparam port_set_t Y_PORTS    = 5'b10100; // north, south

    typedef enum logic [2:0] {
        ALGO_XY         = 3'd0,
        ALGO_WEST_FIRST = 3'd1,
        ALGO_NORTH_LAST = 3'd2,
        ALGO_NEG_FIRST  = 3'd3,
        ALGO_ODD_EVEN   = 3'd4
    } route_algo_t;

    // a and b both low means local
    typedef struct packed {
        logic x; // 1 east, 0 west
        logic y; // 1 north, 0 south
        logic a; // x-direction port allowed
        logic b; // y-direction port allowed
    } dstport_code_t;

endpackage

`default_nettype wire

/* route_compute.sv */
`timescale 1ns/1ns
`default_nettype none

module route_compute
    import mesh_flit_pkg::*;
    import mesh_port_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire flit_t       flit_in,
    input  wire logic        flit_in_wr,
    input  wire logic        flit_in_hdr,
    input  wire x_coord_t    current_x,
    input  wire y_coord_t    current_y,
    input  wire route_algo_t route_algo,
    output logic             push,
    output flit_t            push_flit,
    output logic             push_hdr,
    output port_set_t        push_set,
    output dstport_code_t    push_code
);

    logic          x_plus;
    logic          x_min;
    logic          y_plus;
    logic          y_min;
    logic          same_x;
    logic          same_y;
    logic          x_far;     // two or more columns left going east
    port_idx_t     y_port;    // y-direction port toward the destination
    port_set_t     next_set;
    dstport_code_t next_code;

    // south is the larger row number
    assign same_x = (flit_in.head.dest_x == current_x);
    assign same_y = (flit_in.head.dest_y == current_y);
    assign x_plus = (flit_in.head.dest_x > current_x);
    assign x_min  = (flit_in.head.dest_x < current_x);
    assign y_plus = (flit_in.head.dest_y > current_y);
    assign y_min  = (flit_in.head.dest_y < current_y);

    assign x_far  = (flit_in.head.dest_x != x_coord_t'(current_x + 1'b1));
    assign y_port = y_min ? NORTH : SOUTH;

    // minimal ports allowed by the selected turn model
    always_comb begin
        next_set = '0;
        if (same_x && same_y) begin
            next_set[LOCAL] = 1'b1;
        end else if (same_x) begin
            next_set[y_port] = 1'b1;                // straight along y
        end else if (same_y) begin
            next_set[x_min ? WEST : EAST] = 1'b1;   // straight along x
        end else begin
            case (route_algo)
                ALGO_XY: begin
                    next_set[x_min ? WEST : EAST] = 1'b1;
                end
                ALGO_WEST_FIRST: begin
                    if (x_min) begin
                        next_set[WEST] = 1'b1;      // west only, no turn into west
                    end else begin
                        next_set[EAST]   = 1'b1;
                        next_set[y_port] = 1'b1;
                    end
                end
                ALGO_NORTH_LAST: begin
                    next_set[x_min ? WEST : EAST] = 1'b1;
                    if (y_plus) begin
                        next_set[SOUTH] = 1'b1;     // north waits for same column
                    end
                end
                ALGO_NEG_FIRST: begin
                    if (x_min) begin
                        next_set[WEST] = 1'b1;
                        if (y_plus) begin
                            next_set[SOUTH] = 1'b1;
                        end
                    end else if (y_min) begin
                        next_set[EAST]  = 1'b1;
                        next_set[NORTH] = 1'b1;
                    end else begin
                        next_set[SOUTH] = 1'b1;     // no east to south turn
                    end
                end
                ALGO_ODD_EVEN: begin
                    if (x_plus) begin
                        if (current_x[0]) begin
                            next_set[y_port] = 1'b1;    // odd column
                        end
                        if (flit_in.head.dest_x[0] || x_far) begin
                            next_set[EAST] = 1'b1;
                        end
                    end else begin
                        next_set[WEST] = 1'b1;
                        if (!current_x[0]) begin
                            next_set[y_port] = 1'b1;    // even column
                        end
                    end
                end
                default: begin
                    next_set[x_min ? WEST : EAST] = 1'b1; // unused codes act as xy
                end
            endcase
        end
    end

    assign next_code.x = x_plus;
    assign next_code.y = y_min;
    assign next_code.a = next_set[EAST] | next_set[WEST];
    assign next_code.b = next_set[NORTH] | next_set[SOUTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= flit_in_wr;  // one cycle after the write
        end
    end

    // body flits carry no routing result
    always_ff @(posedge clk) begin
        if (flit_in_wr) begin
            push_flit <= flit_in;
            push_hdr  <= flit_in_hdr;
            push_set  <= flit_in_hdr ? next_set : '0;
            push_code <= flit_in_hdr ? next_code : '0;
        end
    end

endmodule

`default_nettype wire

/* route_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mesh_settings.svh"

module route_fifo
    import mesh_flit_pkg::*;
    import mesh_port_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          push,
    input  wire flit_t         push_flit,
    input  wire logic          push_hdr,
    input  wire port_set_t     push_set,
    input  wire dstport_code_t push_code,
    input  wire logic          pop,
    output flit_t              head_flit,
    output logic               head_hdr,
    output port_set_t          head_set,
    output dstport_code_t      head_code,
    output logic               empty,
    output logic               full
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t             mem_flit [DEPTH];
    logic              mem_hdr  [DEPTH];
    port_set_t         mem_set  [DEPTH];
    dstport_code_t     mem_code [DEPTH];
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W-1:0]  wr_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty   = (count == '0);
    // the entry still in route_compute already has its slot
    assign full    = ((count + CNT_W'(push)) >= CNT_W'(DEPTH));
    assign do_pop  = pop && !empty;
    assign do_push = push && ((count != CNT_W'(DEPTH)) || do_pop);

    assign head_flit = mem_flit[rd_ptr];
    assign head_hdr  = mem_hdr[rd_ptr];
    assign head_set  = mem_set[rd_ptr];
    assign head_code = mem_code[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_flit[wr_ptr] <= push_flit;
            mem_hdr[wr_ptr]  <= push_hdr;
            mem_set[wr_ptr]  <= push_set;
            mem_code[wr_ptr] <= push_code;
        end
    end

endmodule

`default_nettype wire

/* out_port_select.sv */
`timescale 1ns/1ns
`default_nettype none

module out_port_select
    import mesh_flit_pkg::*;
    import mesh_port_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire flit_t         head_flit,
    input  wire logic          head_hdr,
    input  wire port_set_t     head_set,
    input  wire dstport_code_t head_code,
    input  wire logic          empty,
    input  wire port_set_t     port_busy,
    output logic               pop,
    output flit_t              flit_out,
    output logic               flit_out_wr,
    output port_set_t          flit_out_port,
    output dstport_code_t      flit_out_code
);

    port_set_t     cand_x;
    port_set_t     cand_y;
    port_set_t     cand_l;
    port_set_t     head_pick;   // choice for a head flit
    port_set_t     pick;        // port used this cycle or zero when stalled
    port_set_t     lock_port;   // held for the body of the packet
    logic          emit;
    logic          stray;

    // at most one port per direction in any allowed set
    assign cand_x = head_set & X_PORTS;
    assign cand_y = head_set & Y_PORTS;
    assign cand_l = head_set & LOCAL_PORT;

    // busy ports skipped in the order x then y then local
    always_comb begin
        if ((cand_x != '0) && ((cand_x & port_busy) == '0)) begin
            head_pick = cand_x;
        end else if ((cand_y != '0) && ((cand_y & port_busy) == '0)) begin
            head_pick = cand_y;
        end else if ((cand_l != '0) && ((cand_l & port_busy) == '0)) begin
            head_pick = cand_l;
        end else begin
            head_pick = '0;
        end
    end

    always_comb begin
        if (head_hdr) begin
            pick = head_pick;
        end else if ((lock_port & port_busy) == '0) begin
            pick = lock_port;   // wormhole follows the head
        end else begin
            pick = '0;
        end
    end

    assign emit  = !empty && (pick != '0);
    // body flit with no packet open has nowhere to go
    assign stray = !empty && !head_hdr && (lock_port == '0);
    assign pop   = emit || stray;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flit_out_wr <= 1'b0;
            lock_port   <= '0;
        end else begin
            flit_out_wr <= emit;
            if (emit && head_hdr) begin
                lock_port <= head_pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            flit_out      <= head_flit;
            flit_out_port <= pick;
        end
        if (emit && head_hdr) begin
            flit_out_code <= head_code;   // body flits keep the head's code
        end
    end

endmodule

`default_nettype wire

/* mesh_route_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module mesh_route_unit
    import mesh_flit_pkg::*;
    import mesh_port_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire flit_t       flit_in,
    input  wire logic        flit_in_wr,
    input  wire logic        flit_in_hdr,
    input  wire x_coord_t    current_x,
    input  wire y_coord_t    current_y,
    input  wire route_algo_t route_algo,
    input  wire port_set_t   port_busy,
    output logic             fifo_full,
    output flit_t            flit_out,
    output logic             flit_out_wr,
    output port_set_t        flit_out_port,
    output dstport_code_t    flit_out_code
);

    logic          push;
    flit_t         push_flit;
    logic          push_hdr;
    port_set_t     push_set;
    dstport_code_t push_code;
    flit_t         head_flit;
    logic          head_hdr;
    port_set_t     head_set;
    dstport_code_t head_code;
    logic          empty;
    logic          pop;

    route_compute route_compute_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flit_in     (flit_in),
        .flit_in_wr  (flit_in_wr),
        .flit_in_hdr (flit_in_hdr),
        .current_x   (current_x),
        .current_y   (current_y),
        .route_algo  (route_algo),
        .push        (push),
        .push_flit   (push_flit),
        .push_hdr    (push_hdr),
        .push_set    (push_set),
        .push_code   (push_code)
    );

    route_fifo route_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_flit (push_flit),
        .push_hdr  (push_hdr),
        .push_set  (push_set),
        .push_code (push_code),
        .pop       (pop),
        .head_flit (head_flit),
        .head_hdr  (head_hdr),
        .head_set  (head_set),
        .head_code (head_code),
        .empty     (empty),
        .full      (fifo_full)
    );

    out_port_select out_port_select_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .head_flit     (head_flit),
        .head_hdr      (head_hdr),
        .head_set      (head_set),
        .head_code     (head_code),
        .empty         (empty),
        .port_busy     (port_busy),
        .pop           (pop),
        .flit_out      (flit_out),
        .flit_out_wr   (flit_out_wr),
        .flit_out_port (flit_out_port),
        .flit_out_code (flit_out_code)
    );

endmodule

`default_nettype wire

/* mesh_route_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mesh_settings.svh"

module mesh_route_unit_tb
    import mesh_flit_pkg::*;
    import mesh_port_pkg::*;
;

    localparam int CLK_PERIOD  = 40;
    localparam int PHASE_FLITS = 200;
    localparam int STALL_BOUND = 40;  // cycles per flit, worst case with busy bursts
    localparam int WATCHDOG_CYCLES = 5 * ((PHASE_FLITS + 4) * STALL_BOUND + 20) + 500;

    logic          clk;
    logic          rst_n;
    flit_t         flit_in;
    logic          flit_in_wr;
    logic          flit_in_hdr;
    x_coord_t      current_x;
    y_coord_t      current_y;
    route_algo_t   route_algo;
    port_set_t     port_busy;
    logic          fifo_full;
    flit_t         flit_out;
    logic          flit_out_wr;
    port_set_t     flit_out_port;
    dstport_code_t flit_out_code;

    logic [31:0]   rng_state = 32'd41;
    int            burst_left = 0;
    bit            wrote_last = 0;   // writer leaves a gap after each flit
    int            mismatches = 0;
    int            other_errs = 0;
    int            checked = 0;
    int            full_cycles = 0;
    string         phase_name = "reset";

    flit_t         pend_flit[$];     // generated, not yet written
    bit            pend_hdr[$];
    flit_t         exp_flit[$];      // written, not yet seen at the output
    bit            exp_hdr[$];
    port_set_t     exp_set[$];
    dstport_code_t exp_code[$];

    flit_t         e_flit;
    bit            e_hdr;
    port_set_t     e_set;
    dstport_code_t e_code;
    port_set_t     want_port;
    port_set_t     lock_port_m = '0;
    dstport_code_t lock_code_m = '0;
    port_set_t     busy_d1 = '0;     // busy levels of the previous cycle

    mesh_route_unit mesh_route_unit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .flit_in       (flit_in),
        .flit_in_wr    (flit_in_wr),
        .flit_in_hdr   (flit_in_hdr),
        .current_x     (current_x),
        .current_y     (current_y),
        .route_algo    (route_algo),
        .port_busy     (port_busy),
        .fifo_full     (fifo_full),
        .flit_out      (flit_out),
        .flit_out_wr   (flit_out_wr),
        .flit_out_port (flit_out_port),
        .flit_out_code (flit_out_code)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    function automatic port_set_t port_bit(input port_idx_t p);
        return port_set_t'(1) << p;
    endfunction

    function automatic string algo_name(input route_algo_t a);
        case (a)
            ALGO_XY:         return "xy";
            ALGO_WEST_FIRST: return "west_first";
            ALGO_NORTH_LAST: return "north_last";
            ALGO_NEG_FIRST:  return "neg_first";
            default:         return "odd_even";
        endcase
    endfunction

    // turn rules per algorithm, south is the larger row
    function automatic port_set_t route_model(input int dx, input int dy, input int cx,
                                              input int destx, input route_algo_t algo);
        port_set_t s;
        port_set_t xp;
        port_set_t yp;
        s  = '0;
        xp = (dx > 0) ? port_bit(EAST) : port_bit(WEST);
        yp = (dy < 0) ? port_bit(NORTH) : port_bit(SOUTH);
        if (dx == 0 && dy == 0) begin
            s = port_bit(LOCAL);
        end else if (dx == 0) begin
            s = yp;
        end else if (dy == 0) begin
            s = xp;
        end else begin
            case (algo)
                ALGO_WEST_FIRST: s = (dx < 0) ? xp : (xp | yp);
                ALGO_NORTH_LAST: s = (dy > 0) ? (xp | yp) : xp;  // north only in same column
                ALGO_NEG_FIRST: begin
                    if (dx < 0) begin
                        s = (dy > 0) ? (xp | yp) : xp;
                    end else begin
                        s = (dy < 0) ? (xp | yp) : yp;           // east then south is out
                    end
                end
                ALGO_ODD_EVEN: begin
                    if (dx > 0) begin
                        if (cx % 2 == 1) s = s | yp;
                        if (destx % 2 == 1 || dx >= 2) s = s | xp;
                    end else begin
                        s = xp;
                        if (cx % 2 == 0) s = s | yp;
                    end
                end
                default: s = xp;
            endcase
        end
        return s;
    endfunction

    function automatic dstport_code_t code_model(input port_set_t s, input int dx, input int dy);
        dstport_code_t c;
        c.x = (dx > 0);
        c.y = (dy < 0);
        c.a = ((s & (port_bit(EAST) | port_bit(WEST))) != '0);
        c.b = ((s & (port_bit(NORTH) | port_bit(SOUTH))) != '0);
        return c;
    endfunction

    // x port first, then y, then local, each only when free
    function automatic port_set_t pick_model(input port_set_t s, input port_set_t busy);
        port_set_t xs;
        port_set_t ys;
        port_set_t ls;
        xs = s & (port_bit(EAST) | port_bit(WEST));
        ys = s & (port_bit(NORTH) | port_bit(SOUTH));
        ls = s & port_bit(LOCAL);
        if (xs != '0 && (xs & busy) == '0) return xs;
        if (ys != '0 && (ys & busy) == '0) return ys;
        if (ls != '0 && (ls & busy) == '0) return ls;
        return '0;
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else begin
            mismatches++;
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic queue_packet(output int len);
        logic [31:0] r;
        flit_t       f;
        next_rand(r);
        f.head.dest_x = x_coord_t'(r % `NX);
        f.head.dest_y = y_coord_t'((r >> 4) % `NY);
        f.head.tag    = r[20 +: TAG_W];
        pend_flit.push_back(f);
        pend_hdr.push_back(1'b1);
        len = 1 + r[9:8];  // head plus up to three body flits
        for (int i = 1; i < len; i++) begin
            next_rand(r);
            f.payload = r[15:0];
            pend_flit.push_back(f);
            pend_hdr.push_back(1'b0);
        end
    endtask

    // one clock of stimulus: busy levels and at most one write
    task automatic step_cycle();
        logic [31:0] r;
        logic [31:0] rb;
        flit_t       f;
        bit          h;
        port_set_t   s;
        int          dx;
        int          dy;
        @(posedge clk);
        next_rand(r);
        next_rand(rb);
        if (burst_left != 0) begin
            port_busy <= '1;
            burst_left--;
        end else if (rb[31:26] == 6'd0) begin
            burst_left = 16 + rb[3:0];  // long stall fills the queue
            port_busy <= '1;
        end else begin
            port_busy <= port_set_t'(rb[4:0] & rb[9:5]);
        end
        flit_in_wr <= 1'b0;
        if (pend_flit.size() != 0 && !wrote_last && !fifo_full && r[7:6] != 2'b00) begin
            f = pend_flit.pop_front();
            h = pend_hdr.pop_front();
            flit_in     <= f;
            flit_in_hdr <= h;
            flit_in_wr  <= 1'b1;
            dx = int'(f.head.dest_x) - int'(current_x);
            dy = int'(f.head.dest_y) - int'(current_y);
            s  = h ? route_model(dx, dy, current_x, f.head.dest_x, route_algo) : '0;
            exp_flit.push_back(f);
            exp_hdr.push_back(h);
            exp_set.push_back(s);
            exp_code.push_back(h ? code_model(s, dx, dy) : dstport_code_t'('0));
            wrote_last = 1;
        end else begin
            wrote_last = 0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n      <= 1'b0;
        flit_in_wr <= 1'b0;
        wrote_last = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!fifo_full && !flit_out_wr) else begin
            other_errs++;
            $display("fifo_full or flit_out_wr is high right after reset");
        end
    endtask

    task automatic run_phase(input route_algo_t algo);
        logic [31:0] r;
        int          n;
        int          len;
        int          cycles;
        int          full_before;
        phase_name = algo_name(algo);
        next_rand(r);
        route_algo <= algo;
        current_x  <= x_coord_t'(r % `NX);
        current_y  <= y_coord_t'((r >> 8) % `NY);
        apply_reset();
        full_before = full_cycles;
        n = 0;
        while (n < PHASE_FLITS) begin
            queue_packet(len);
            n += len;
        end
        cycles = 0;
        while ((pend_flit.size() != 0 || exp_flit.size() != 0) &&
               cycles < PHASE_FLITS * STALL_BOUND) begin
            step_cycle();
            cycles++;
        end
        repeat (4) step_cycle();  // catch any extra output
        assert (pend_flit.size() == 0 && exp_flit.size() == 0) else begin
            other_errs++;
            $display("%s phase: %0d flits never left the unit", phase_name, exp_flit.size());
        end
        assert (full_cycles > full_before) else begin
            other_errs++;
            $display("%s phase: fifo_full never went high during busy bursts", phase_name);
        end
    endtask

    // output monitor, compares each emitted flit with the model
    always @(posedge clk) begin
        if (rst_n && flit_out_wr) begin
            if (exp_flit.size() == 0) begin
                other_errs++;
                $display("%s: flit %h came out with none outstanding", phase_name, flit_out);
            end else begin
                e_flit = exp_flit.pop_front();
                e_hdr  = exp_hdr.pop_front();
                e_set  = exp_set.pop_front();
                e_code = exp_code.pop_front();
                if (e_hdr) begin
                    want_port = pick_model(e_set, busy_d1);
                    assert ((flit_out_port & ~e_set) == '0) else begin
                        other_errs++;
                        $display("%s: port %b is outside the allowed set %b",
                                 phase_name, flit_out_port, e_set);
                    end
                    lock_port_m = want_port;
                    lock_code_m = e_code;
                end else begin
                    want_port = ((lock_port_m & busy_d1) == '0) ? lock_port_m : '0;
                end
                check_value(phase_name, "port", want_port, flit_out_port);
                check_value(phase_name, "code", lock_code_m, flit_out_code);
                check_value(phase_name, "flit", e_flit, flit_out);
                checked++;
            end
        end
        if (rst_n && fifo_full) begin
            full_cycles++;
        end
        assert (!(rst_n && flit_in_wr && fifo_full)) else begin
            other_errs++;
            $display("%s: a flit was written while fifo_full was high", phase_name);
        end
        busy_d1 = port_busy;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles, flits stuck in %s phase",
                 WATCHDOG_CYCLES, phase_name);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        flit_in     = '0;
        flit_in_wr  = 1'b0;
        flit_in_hdr = 1'b0;
        current_x   = '0;
        current_y   = '0;
        route_algo  = ALGO_XY;
        port_busy   = '0;
        for (int a = 0; a < 5; a++) begin
            run_phase(route_algo_t'(a));
        end
        $display("checked %0d flits: %0d mismatches, %0d other errors",
                 checked, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mesh_route_unit.f */
+incdir+.
mesh_flit_pkg.sv
mesh_port_pkg.sv
route_compute.sv
route_fifo.sv
out_port_select.sv
mesh_route_unit.sv
mesh_route_unit_tb.sv

/* Bender.yml */
package:
  name: mesh_route_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mesh_flit_pkg.sv
      - mesh_port_pkg.sv
      - route_compute.sv
      - route_fifo.sv
      - out_port_select.sv
      - mesh_route_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - mesh_route_unit_tb.sv
